/* source/reg_pkg.sv */
package reg_pkg;

    // data path widths
    localparam int word_width     = 32;
    localparam int reg_addr_width = 6;
    localparam int reg_count      = 2 ** reg_addr_width;

    // one bit per outstanding branch tag
    localparam int context_width = 4;

    // fixed register addresses
    localparam logic [reg_addr_width-1:0] zero_reg_addr = '0;
    localparam logic [reg_addr_width-1:0] link_reg_addr = 6'd1;

    // a register with this context has no write pending
    localparam logic [context_width-1:0] context_free = '0;

    // decoded request, one per cycle from decode
    typedef struct packed {
        logic                      rs1_en;
        logic [reg_addr_width-1:0] rs1;
        logic                      rs2_en;
        logic [reg_addr_width-1:0] rs2;
        logic                      rd_en;
        logic [reg_addr_width-1:0] rd;
        // branch tags this instruction runs under
        logic [context_width-1:0]  branch_context;
    } inst_vreg_t;

    // operands and grants handed back to decode
    typedef struct packed {
        logic                      rs1_ready;
        logic [word_width-1:0]     rs1_data;
        logic                      rs2_ready;
        logic [word_width-1:0]     rs2_data;
        logic                      rd_ready;
        logic [reg_addr_width-1:0] rd;
        logic                      squashed;
    } inst_issue_t;

    // result coming back from execute
    typedef struct packed {
        logic                      valid;
        logic [reg_addr_width-1:0] rd;
        logic [word_width-1:0]     data;
    } write_back_t;

endpackage

/* source/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file import reg_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire write_back_t               write_back,
    input  wire logic [reg_addr_width-1:0] rs1_addr,
    input  wire logic [reg_addr_width-1:0] rs2_addr,
    output logic      [word_width-1:0]     rs1_raw,
    output logic      [word_width-1:0]     rs2_raw,
    output logic      [word_width-1:0]     lr_data
);

    logic [word_width-1:0] regs [reg_count];
    logic                  wr_en;

    // register 0 is hardwired, never written
    assign wr_en = write_back.valid && (write_back.rd != zero_reg_addr);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[write_back.rd] <= write_back.data;
        end
    end

    // asynchronous read ports
    assign rs1_raw = regs[rs1_addr];
    assign rs2_raw = regs[rs2_addr];

    // link register tap, no forwarding here
    assign lr_data = regs[link_reg_addr];

endmodule

`default_nettype wire

/* source/reg_context_table.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_context_table import reg_pkg::*; (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire inst_vreg_t               inst,
    input  wire inst_issue_t              issue,
    input  wire write_back_t              write_back,
    input  wire logic                     branch_hazard,
    input  wire logic [context_width-1:0] hazard_context,
    output logic      [reg_count-1:0]     pending
);

    // stored context per register
    logic [context_width-1:0] ctx_q [reg_count];

    // context after write-back and squash of this cycle
    logic [context_width-1:0] ctx_eff [reg_count];

    // value loaded at the next edge
    logic [context_width-1:0] ctx_next [reg_count];

    logic claim;

    // a granted claim on a real register
    assign claim = issue.rd_ready && (inst.rd != zero_reg_addr);

    always_comb begin
        for (int r = 0; r < reg_count; r++) begin
            logic wb_hit;
            logic hz_hit;

            wb_hit = write_back.valid && (write_back.rd == r[reg_addr_width-1:0]);
            hz_hit = branch_hazard && (|(ctx_q[r] & hazard_context));

            if (r == 0 || wb_hit || hz_hit) begin
                ctx_eff[r] = context_free;
            end else begin
                ctx_eff[r] = ctx_q[r];
            end

            pending[r] = |ctx_eff[r];
        end
    end

    // carry effective contexts forward and overlay the claim
    always_comb begin
        for (int r = 0; r < reg_count; r++) begin
            if (claim && (inst.rd == r[reg_addr_width-1:0])) begin
                ctx_next[r] = inst.branch_context;
            end else begin
                ctx_next[r] = ctx_eff[r];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < reg_count; r++) begin
                ctx_q[r] <= context_free;
            end
        end else begin
            for (int r = 0; r < reg_count; r++) begin
                ctx_q[r] <= ctx_next[r];
            end
        end
    end

endmodule

`default_nettype wire

/* source/reg_operand_read.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_operand_read import reg_pkg::*; (
    input  wire inst_vreg_t               inst,
    input  wire write_back_t              write_back,
    input  wire logic [word_width-1:0]    rs1_raw,
    input  wire logic [word_width-1:0]    rs2_raw,
    input  wire logic [reg_count-1:0]     pending,
    input  wire logic                     branch_hazard,
    input  wire logic [context_width-1:0] hazard_context,
    output inst_issue_t                   issue
);

    logic squash;

    // forwarding hits, register 0 excluded
    logic rs1_fwd;
    logic rs2_fwd;

    logic [word_width-1:0] rs1_data;
    logic [word_width-1:0] rs2_data;

    logic rs1_ready;
    logic rs2_ready;
    logic rd_ready;

    // instruction runs under a tag being killed
    assign squash = branch_hazard && (|(inst.branch_context & hazard_context));

    assign rs1_fwd = write_back.valid
                  && (write_back.rd == inst.rs1)
                  && (inst.rs1 != zero_reg_addr);
    assign rs2_fwd = write_back.valid
                  && (write_back.rd == inst.rs2)
                  && (inst.rs2 != zero_reg_addr);

    assign rs1_data = rs1_fwd ? write_back.data : rs1_raw;
    assign rs2_data = rs2_fwd ? write_back.data : rs2_raw;

    // pending already accounts for this cycle's write-back
    assign rs1_ready = inst.rs1_en && !squash && !pending[inst.rs1];
    assign rs2_ready = inst.rs2_en && !squash && !pending[inst.rs2];

    // destination claim, stalls until the old write lands
    assign rd_ready = inst.rd_en && !squash && !pending[inst.rd];

    always_comb begin
        issue.rs1_ready = rs1_ready;
        issue.rs1_data  = rs1_data;
        issue.rs2_ready = rs2_ready;
        issue.rs2_data  = rs2_data;
        issue.rd_ready  = rd_ready;
        issue.rd        = inst.rd;
        issue.squashed  = squash;
    end

endmodule

`default_nettype wire

/* source/reg_manage.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_manage import reg_pkg::*; (
    input  wire inst_vreg_t               inst,
    output inst_issue_t                   issue,
    input  wire write_back_t              write_back,
    output logic      [word_width-1:0]    lr_data,
    input  wire logic                     branch_hazard,
    input  wire logic [context_width-1:0] hazard_context,
    input  wire logic                     clk,
    input  wire logic                     reset
);

    logic [word_width-1:0] rs1_raw;
    logic [word_width-1:0] rs2_raw;
    logic [reg_count-1:0]  pending;

    // physical address equals the decoded one
    reg_file reg_file_i (
        .clk        (clk),
        .reset      (reset),
        .write_back (write_back),
        .rs1_addr   (inst.rs1),
        .rs2_addr   (inst.rs2),
        .rs1_raw    (rs1_raw),
        .rs2_raw    (rs2_raw),
        .lr_data    (lr_data)
    );

    reg_context_table reg_context_table_i (
        .clk            (clk),
        .reset          (reset),
        .inst           (inst),
        .issue          (issue),
        .write_back     (write_back),
        .branch_hazard  (branch_hazard),
        .hazard_context (hazard_context),
        .pending        (pending)
    );

    // combinational issue path back to decode
    reg_operand_read reg_operand_read_i (
        .inst           (inst),
        .write_back     (write_back),
        .rs1_raw        (rs1_raw),
        .rs2_raw        (rs2_raw),
        .pending        (pending),
        .branch_hazard  (branch_hazard),
        .hazard_context (hazard_context),
        .issue          (issue)
    );

endmodule

`default_nettype wire

/* verification/reg_manage_tasks.svh */
// idle value on every DUT input
task automatic clear_inputs();
    inst           = '0;
    write_back     = '0;
    branch_hazard  = 1'b0;
    hazard_context = '0;
endtask

task automatic drive_request(
    input logic                      rs1_en,
    input logic [reg_addr_width-1:0] rs1,
    input logic                      rs2_en,
    input logic [reg_addr_width-1:0] rs2,
    input logic                      rd_en,
    input logic [reg_addr_width-1:0] rd,
    input logic [context_width-1:0]  ctx
);
    inst.rs1_en         = rs1_en;
    inst.rs1            = rs1;
    inst.rs2_en         = rs2_en;
    inst.rs2            = rs2;
    inst.rd_en          = rd_en;
    inst.rd             = rd;
    inst.branch_context = ctx;
endtask

// one-cycle pulse, cleared by run_cycle
task automatic drive_write_back(
    input logic [reg_addr_width-1:0] rd,
    input logic [word_width-1:0]     data
);
    write_back.valid = 1'b1;
    write_back.rd    = rd;
    write_back.data  = data;
endtask

task automatic drive_hazard(input logic [context_width-1:0] mask);
    branch_hazard  = 1'b1;
    hazard_context = mask;
endtask

task automatic check_issue(input inst_issue_t expected, input inst_issue_t actual);
    if (actual.rs1_ready !== expected.rs1_ready) begin
        $display("Mismatch at %0t: issue.rs1_ready expected %0b got %0b",
                 $time, expected.rs1_ready, actual.rs1_ready);
        error_count++;
    end
    if (actual.rs1_data !== expected.rs1_data) begin
        $display("Mismatch at %0t: issue.rs1_data expected %08h got %08h",
                 $time, expected.rs1_data, actual.rs1_data);
        error_count++;
    end
    if (actual.rs2_ready !== expected.rs2_ready) begin
        $display("Mismatch at %0t: issue.rs2_ready expected %0b got %0b",
                 $time, expected.rs2_ready, actual.rs2_ready);
        error_count++;
    end
    if (actual.rs2_data !== expected.rs2_data) begin
        $display("Mismatch at %0t: issue.rs2_data expected %08h got %08h",
                 $time, expected.rs2_data, actual.rs2_data);
        error_count++;
    end
    if (actual.rd_ready !== expected.rd_ready) begin
        $display("Mismatch at %0t: issue.rd_ready expected %0b got %0b",
                 $time, expected.rd_ready, actual.rd_ready);
        error_count++;
    end
    if (actual.rd !== expected.rd) begin
        $display("Mismatch at %0t: issue.rd expected %0d got %0d",
                 $time, expected.rd, actual.rd);
        error_count++;
    end
    if (actual.squashed !== expected.squashed) begin
        $display("Mismatch at %0t: issue.squashed expected %0b got %0b",
                 $time, expected.squashed, actual.squashed);
        error_count++;
    end
endtask

task automatic check_word(
    input string                 name,
    input logic [word_width-1:0] expected,
    input logic [word_width-1:0] actual
);
    if (actual !== expected) begin
        $display("Mismatch at %0t: %s expected %08h got %08h", $time, name, expected, actual);
        error_count++;
    end
endtask

task automatic confirm(input logic cond, input string what);
    if (cond !== 1'b1) begin
        $display("Error at %0t: %s", $time, what);
        error_count++;
    end
endtask

// check just before the edge, then advance the model with the same inputs
task automatic run_cycle();
    inst_issue_t           expected;
    logic [word_width-1:0] expected_lr;

    #(clk_period - 2 * drive_delay);
    expected    = predict_issue(inst, write_back, branch_hazard, hazard_context);
    expected_lr = model_data[link_reg_addr];
    check_issue(expected, issue);
    check_word("lr_data", expected_lr, lr_data);
    last_issue = issue;
    last_lr    = lr_data;
    @(posedge clk);
    update_model(inst, write_back, branch_hazard, hazard_context, expected.rd_ready);
    #(drive_delay);
    write_back.valid = 1'b0;
    branch_hazard    = 1'b0;
endtask

task automatic test_after_reset();
    clear_inputs();
    drive_request(1'b1, 6'd5, 1'b1, 6'd63, 1'b1, 6'd7, 4'b0000);
    run_cycle();
    confirm(last_issue.rs1_ready && last_issue.rs2_ready && last_issue.rd_ready,
            "a ready flag was low right after reset");
    confirm(last_issue.rs1_data == '0 && last_issue.rs2_data == '0,
            "operand data was not zero after reset");
    confirm(!last_issue.squashed, "instruction squashed with no hazard");
    confirm(last_lr == '0, "lr_data was not zero after reset");
endtask

task automatic test_write_read();
    logic [reg_addr_width-1:0] addrs [6];
    logic [word_width-1:0]     value;

    clear_inputs();
    for (int i = 0; i < 6; i++) begin
        addrs[i] = reg_addr_width'($urandom_range(63, 2));
        value    = $urandom();
        drive_write_back(addrs[i], value);
        run_cycle();
    end
    drive_write_back(zero_reg_addr, $urandom());
    run_cycle();
    for (int i = 0; i < 6; i++) begin
        drive_request(1'b1, addrs[i], 1'b1, addrs[5 - i], 1'b0, '0, '0);
        run_cycle();
        confirm(last_issue.rs1_data == model_data[addrs[i]], "written value not read back");
    end
    drive_request(1'b1, zero_reg_addr, 1'b1, zero_reg_addr, 1'b0, '0, '0);
    run_cycle();
    confirm(last_issue.rs1_data == '0 && last_issue.rs2_data == '0,
            "register 0 did not read as zero after a write");
endtask

task automatic test_claim_stall();
    logic [reg_addr_width-1:0] r;
    logic [word_width-1:0]     value;

    r     = 6'd20;
    value = $urandom();
    clear_inputs();
    drive_request(1'b0, '0, 1'b0, '0, 1'b1, r, 4'b0100);
    run_cycle();
    confirm(last_issue.rd_ready, "claim on a free register was refused");
    drive_request(1'b1, r, 1'b1, r, 1'b1, r, 4'b0100);
    repeat (2) begin
        run_cycle();
        confirm(!last_issue.rs1_ready && !last_issue.rs2_ready,
                "source naming a pending register was ready");
        confirm(!last_issue.rd_ready, "claim on a pending register was granted");
    end
    drive_write_back(r, value);
    run_cycle();
    confirm(last_issue.rs1_ready && last_issue.rs1_data == value,
            "write-back was not forwarded to the source");
    confirm(last_issue.rd_ready, "claim in the write-back cycle was refused");
    // the new claim holds the register again
    drive_request(1'b1, r, 1'b0, '0, 1'b0, '0, '0);
    run_cycle();
    confirm(!last_issue.rs1_ready, "register free after a granted reclaim");
    clear_inputs();
    drive_write_back(r, value + 1);
    run_cycle();
endtask

task automatic test_zero_reg();
    clear_inputs();
    drive_request(1'b0, '0, 1'b0, '0, 1'b1, zero_reg_addr, 4'b0101);
    run_cycle();
    confirm(last_issue.rd_ready, "claim on register 0 was refused");
    drive_request(1'b1, zero_reg_addr, 1'b0, '0, 1'b1, zero_reg_addr, 4'b0101);
    run_cycle();
    confirm(last_issue.rs1_ready && last_issue.rd_ready, "register 0 became pending");
    confirm(last_issue.rs1_data == '0, "register 0 did not read as zero");
endtask

task automatic test_branch_hazard();
    logic [reg_addr_width-1:0] ra;
    logic [reg_addr_width-1:0] rb;

    ra = 6'd30;
    rb = 6'd31;
    clear_inputs();
    drive_request(1'b0, '0, 1'b0, '0, 1'b1, ra, 4'b0001);
    run_cycle();
    drive_request(1'b0, '0, 1'b0, '0, 1'b1, rb, 4'b0010);
    run_cycle();
    drive_request(1'b1, ra, 1'b1, rb, 1'b1, 6'd32, 4'b0011);
    drive_hazard(4'b0001);
    run_cycle();
    confirm(last_issue.squashed, "instruction under a killed tag was not squashed");
    confirm(!last_issue.rs1_ready && !last_issue.rs2_ready && !last_issue.rd_ready,
            "squashed instruction had a ready flag set");
    drive_request(1'b1, ra, 1'b1, rb, 1'b0, '0, 4'b0000);
    run_cycle();
    confirm(last_issue.rs1_ready, "hazard did not clear the 0001 register");
    confirm(!last_issue.rs2_ready, "hazard cleared the 0010 register");
    // retire the surviving claim
    clear_inputs();
    drive_write_back(rb, $urandom());
    run_cycle();
endtask

task automatic test_link_register();
    logic [word_width-1:0] value;

    value = $urandom();
    clear_inputs();
    drive_write_back(link_reg_addr, value);
    run_cycle();
    run_cycle();
    confirm(last_lr == value, "lr_data did not follow a write to register 1");
endtask

/* verification/reg_manage_tb.sv */
`timescale 1ns/1ns

module reg_manage_tb import reg_pkg::*; ();

    localparam int clk_period     = 20;
    localparam int drive_delay    = 2;
    localparam int reset_cycles   = 5;
    localparam int test_count     = 6;
    localparam int timeout_cycles = test_count * 40 + 20;

    logic                     clk;
    logic                     reset;
    inst_vreg_t               inst;
    inst_issue_t              issue;
    write_back_t              write_back;
    logic [word_width-1:0]    lr_data;
    logic                     branch_hazard;
    logic [context_width-1:0] hazard_context;

    // reference model state
    logic [word_width-1:0]    model_data [reg_count];
    logic [context_width-1:0] model_ctx  [reg_count];

    // outputs seen in the last checked cycle
    inst_issue_t           last_issue;
    logic [word_width-1:0] last_lr;

    int          error_count;

    reg_manage dut_i (
        .inst           (inst),
        .issue          (issue),
        .write_back     (write_back),
        .lr_data        (lr_data),
        .branch_hazard  (branch_hazard),
        .hazard_context (hazard_context),
        .clk            (clk),
        .reset          (reset)
    );

    `include "reg_manage_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // context of a register once this cycle's write-back and hazard are applied
    function automatic logic [context_width-1:0] effective_context(
        input logic [reg_addr_width-1:0] r,
        input write_back_t               wb,
        input logic                      hz,
        input logic [context_width-1:0]  mask
    );
        if (r == zero_reg_addr) begin
            return '0;
        end
        if (wb.valid && wb.rd == r) begin
            return '0;
        end
        if (hz && ((model_ctx[r] & mask) != '0)) begin
            return '0;
        end
        return model_ctx[r];
    endfunction

    function automatic logic [word_width-1:0] read_operand(
        input logic [reg_addr_width-1:0] r,
        input write_back_t               wb
    );
        // forwarding from the write-back port
        if (r != zero_reg_addr && wb.valid && wb.rd == r) begin
            return wb.data;
        end
        return model_data[r];
    endfunction

    function automatic inst_issue_t predict_issue(
        input inst_vreg_t               req,
        input write_back_t              wb,
        input logic                     hz,
        input logic [context_width-1:0] mask
    );
        inst_issue_t exp;
        logic        kill;

        kill = hz && ((req.branch_context & mask) != '0);
        exp.squashed  = kill;
        exp.rd        = req.rd;
        exp.rs1_ready = req.rs1_en && !kill && (effective_context(req.rs1, wb, hz, mask) == '0);
        exp.rs2_ready = req.rs2_en && !kill && (effective_context(req.rs2, wb, hz, mask) == '0);
        exp.rd_ready  = req.rd_en && !kill && (effective_context(req.rd, wb, hz, mask) == '0);
        exp.rs1_data  = read_operand(req.rs1, wb);
        exp.rs2_data  = read_operand(req.rs2, wb);
        return exp;
    endfunction

    task automatic update_model(
        input inst_vreg_t               req,
        input write_back_t              wb,
        input logic                     hz,
        input logic [context_width-1:0] mask,
        input logic                     granted
    );
        logic [context_width-1:0] next_ctx [reg_count];

        for (int r = 0; r < reg_count; r++) begin
            next_ctx[r] = effective_context(reg_addr_width'(r), wb, hz, mask);
        end
        if (granted && req.rd != zero_reg_addr) begin
            next_ctx[req.rd] = req.branch_context;
        end
        for (int r = 0; r < reg_count; r++) begin
            model_ctx[r] = next_ctx[r];
        end
        if (wb.valid && wb.rd != zero_reg_addr) begin
            model_data[wb.rd] = wb.data;
        end
    endtask

    task automatic reset_model();
        for (int r = 0; r < reg_count; r++) begin
            model_data[r] = '0;
            model_ctx[r]  = '0;
        end
    endtask

    initial begin
        error_count = 0;
        void'($urandom(6592));
        reset       = 1'b1;
        clear_inputs();
        reset_model();
        repeat (reset_cycles) @(posedge clk);
        #(drive_delay);
        reset = 1'b0;

        test_after_reset();
        test_write_read();
        test_claim_stall();
        test_zero_reg();
        test_branch_hazard();
        test_link_register();

        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
        $display("Errors: %0d", error_count + 1);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* flist.f */
+incdir+verification
source/reg_pkg.sv
source/reg_file.sv
source/reg_context_table.sv
source/reg_operand_read.sv
source/reg_manage.sv
verification/reg_manage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log
rm -f "$build_log" "$sim_log"

verilator --binary --timing --timescale 1ns/1ns \
    --top-module reg_manage_tb -f flist.f -o reg_manage_sim > "$build_log" 2>&1 \
    && ./obj_dir/reg_manage_sim > "$sim_log" 2>&1 \
    || { cat "$build_log"; echo "build or run failed"; exit 1; }

cat "$sim_log"

grep -qx "Finished with errors" "$sim_log" && { echo "simulation FAILED"; exit 1; }
grep -qx "Finished with no errors" "$sim_log" \
    || { echo "simulation ended without a result"; exit 1; }

echo "simulation passed"
exit 0
